//--- source/uce_params.svh
`ifndef UCE_PARAMS_SVH
`define UCE_PARAMS_SVH

// address and block geometry
`define UCE_PADDR_WIDTH 32
`define UCE_BLOCK_WIDTH 256
`define UCE_FILL_WIDTH 64
`define UCE_DWORD_WIDTH 64
`define UCE_SETS 16
`define UCE_ASSOC 4

// memory commands that may be in flight
`define UCE_MAX_CREDITS 4

// derived values
`define UCE_BEATS (`UCE_BLOCK_WIDTH / `UCE_FILL_WIDTH)
`define UCE_BEAT_CNT_WIDTH ($clog2(`UCE_BEATS))
`define UCE_BLOCK_OFFSET_WIDTH ($clog2(`UCE_BLOCK_WIDTH / 8))
`define UCE_FILL_OFFSET_WIDTH ($clog2(`UCE_FILL_WIDTH / 8))
`define UCE_INDEX_WIDTH ($clog2(`UCE_SETS))
`define UCE_WAY_WIDTH ($clog2(`UCE_ASSOC))
`define UCE_TAG_WIDTH (`UCE_PADDR_WIDTH - `UCE_INDEX_WIDTH - `UCE_BLOCK_OFFSET_WIDTH)
`define UCE_CREDIT_WIDTH ($clog2(`UCE_MAX_CREDITS + 1))

`endif

//--- source/uce_pkg.sv
`default_nettype none

`include "uce_params.svh"

package uce_pkg;

  // cache side request
  typedef enum logic [1:0]
  {
    e_miss_load,
    e_uc_load,
    e_uc_store
  } cache_req_type_e;

  typedef enum logic [1:0]
  {
    e_size_1,
    e_size_2,
    e_size_4,
    e_size_8
  } req_size_e;

  typedef struct packed
  {
    cache_req_type_e               msg_type;
    logic [`UCE_PADDR_WIDTH-1:0]   addr;
    req_size_e                     size;
    logic [`UCE_WAY_WIDTH-1:0]     way;
    logic [`UCE_DWORD_WIDTH-1:0]   data;
  } cache_req_s;

  // memory command and response share one layout
  typedef enum logic [1:0]
  {
    e_mem_rd,
    e_mem_uc_rd,
    e_mem_uc_wr
  } mem_msg_type_e;

  typedef struct packed
  {
    mem_msg_type_e                 msg_type;
    logic [`UCE_PADDR_WIDTH-1:0]   addr;
    req_size_e                     size;
    logic [`UCE_WAY_WIDTH-1:0]     way;
    logic [`UCE_FILL_WIDTH-1:0]    data;
  } mem_msg_s;

  typedef enum logic
  {
    e_coh_i,
    e_coh_m
  } coh_state_e;

  typedef enum logic
  {
    e_tag_clear,
    e_tag_set
  } tag_mem_opcode_e;

  typedef struct packed
  {
    tag_mem_opcode_e               opcode;
    logic [`UCE_INDEX_WIDTH-1:0]   index;
    logic [`UCE_WAY_WIDTH-1:0]     way;
    logic [`UCE_TAG_WIDTH-1:0]     tag;
    coh_state_e                    state;
  } tag_mem_pkt_s;

  typedef enum logic
  {
    e_data_write,
    e_data_uncached
  } data_mem_opcode_e;

  // fill_index is one-hot over the beats of a block
  typedef struct packed
  {
    data_mem_opcode_e              opcode;
    logic [`UCE_INDEX_WIDTH-1:0]   index;
    logic [`UCE_WAY_WIDTH-1:0]     way;
    logic [`UCE_BEATS-1:0]         fill_index;
    logic [`UCE_FILL_WIDTH-1:0]    data;
  } data_mem_pkt_s;

endpackage

`default_nettype wire

//--- source/uce_credit_counter.sv
`timescale 1ns/1ps
`default_nettype none

`include "uce_params.svh"

module uce_credit_counter
  (input  logic   clk_i
   , input  logic reset_i
   , input  logic cmd_sent_i
   , input  logic resp_taken_i
   , output logic credits_full_o
   , output logic credits_empty_o
   );

  localparam logic [`UCE_CREDIT_WIDTH-1:0] max_credits_lp = `UCE_MAX_CREDITS;

  logic [`UCE_CREDIT_WIDTH-1:0] count_r;

  // a send and a return in the same cycle leave the count alone
  always_ff @(posedge clk_i)
  begin
    if (reset_i)
      count_r <= '0;
    else if (cmd_sent_i && !resp_taken_i)
      count_r <= count_r + 1'b1;
    else if (!cmd_sent_i && resp_taken_i)
      count_r <= count_r - 1'b1;
  end

  assign credits_full_o  = (count_r == max_credits_lp);
  assign credits_empty_o = (count_r == '0);

  // the command stage must stop issuing once every credit is out
  assert property (@(posedge clk_i) disable iff (reset_i)
    credits_full_o |-> !(cmd_sent_i && !resp_taken_i))
    else $error("credit counter overflow");

  // memory never answers a command that was not sent
  assert property (@(posedge clk_i) disable iff (reset_i)
    credits_empty_o |-> !resp_taken_i)
    else $error("credit counter underflow");

endmodule

`default_nettype wire

//--- source/uce_cmd_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "uce_params.svh"

module uce_cmd_stage
  (input  logic                  clk_i
   , input  logic                reset_i

   , input  uce_pkg::cache_req_s cache_req_i
   , input  logic                cache_req_v_i
   , output logic                cache_req_yumi_o
   , output logic                cache_req_busy_o

   , output uce_pkg::mem_msg_s   mem_cmd_o
   , output logic                mem_cmd_v_o
   , input  logic                mem_cmd_ready_i

   , input  logic                sweep_done_i
   , input  logic                credits_full_i
   , input  logic                req_complete_i
   );

  typedef enum logic [1:0]
  {
    e_ready,
    e_send,
    e_wait
  } state_e;

  state_e state_r, state_n;

  uce_pkg::cache_req_s req_r;
  logic [`UCE_BEAT_CNT_WIDTH-1:0] beat_cnt_r;
  logic [`UCE_BEAT_CNT_WIDTH-1:0] crit_beat;
  logic is_ready;
  logic new_is_store;
  logic req_is_miss;
  logic last_beat;
  logic beat_up;

  assign is_ready     = (state_r == e_ready);
  assign new_is_store = (cache_req_i.msg_type == uce_pkg::e_uc_store);
  assign req_is_miss  = (req_r.msg_type == uce_pkg::e_miss_load);

  // the beat before the critical one closes the wrap
  assign crit_beat = req_r.addr[`UCE_BLOCK_OFFSET_WIDTH-1 -: `UCE_BEAT_CNT_WIDTH];
  assign last_beat = (beat_cnt_r + 1'b1 == crit_beat);

  assign cache_req_busy_o = !sweep_done_i || credits_full_i || !is_ready;
  assign cache_req_yumi_o = cache_req_v_i && !cache_req_busy_o && mem_cmd_ready_i;

  always_comb
  begin
    mem_cmd_o   = '0;
    mem_cmd_v_o = 1'b0;
    beat_up     = 1'b0;
    state_n     = state_r;

    unique case (state_r)
      e_ready:
      begin
        // stores go straight out with the accept
        if (new_is_store)
        begin
          mem_cmd_o.msg_type = uce_pkg::e_mem_uc_wr;
          mem_cmd_o.addr     = cache_req_i.addr;
          mem_cmd_o.size     = cache_req_i.size;
          mem_cmd_o.way      = cache_req_i.way;
          mem_cmd_o.data[`UCE_DWORD_WIDTH-1:0] = cache_req_i.data;
          mem_cmd_v_o        = cache_req_yumi_o;
        end
        else if (cache_req_yumi_o)
          state_n = e_send;
      end
      e_send:
      begin
        mem_cmd_o.way = req_r.way;
        mem_cmd_v_o   = mem_cmd_ready_i && !credits_full_i;
        if (req_is_miss)
        begin
          mem_cmd_o.msg_type = uce_pkg::e_mem_rd;
          mem_cmd_o.addr     = {req_r.addr[`UCE_PADDR_WIDTH-1:`UCE_BLOCK_OFFSET_WIDTH],
                                beat_cnt_r, {`UCE_FILL_OFFSET_WIDTH{1'b0}}};
          mem_cmd_o.size     = uce_pkg::e_size_8;
          beat_up            = mem_cmd_v_o;
          if (mem_cmd_v_o && last_beat)
            state_n = e_wait;
        end
        else
        begin
          mem_cmd_o.msg_type = uce_pkg::e_mem_uc_rd;
          mem_cmd_o.addr     = req_r.addr;
          mem_cmd_o.size     = req_r.size;
          if (mem_cmd_v_o)
            state_n = e_wait;
        end
      end
      e_wait:
      begin
        if (req_complete_i)
          state_n = e_ready;
      end
      default:
      begin
        state_n = e_ready;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      state_r    <= e_ready;
      beat_cnt_r <= '0;
    end
    else
    begin
      state_r <= state_n;
      // start at the critical beat of the new request
      if (cache_req_yumi_o)
        beat_cnt_r <= cache_req_i.addr[`UCE_BLOCK_OFFSET_WIDTH-1 -: `UCE_BEAT_CNT_WIDTH];
      else if (beat_up)
        beat_cnt_r <= beat_cnt_r + 1'b1;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (cache_req_yumi_o && !new_is_store)
      req_r <= cache_req_i;
  end

  // the fill stage only completes a load or miss that is held here
  assert property (@(posedge clk_i) disable iff (reset_i)
    is_ready |-> !req_complete_i)
    else $error("completion with no request held");

  // every beat of a miss went out once the stage waits
  assert property (@(posedge clk_i) disable iff (reset_i)
    (state_r == e_wait) && req_is_miss |-> beat_cnt_r == crit_beat)
    else $error("miss left beats unsent");

endmodule

`default_nettype wire

//--- source/uce_fill_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "uce_params.svh"

module uce_fill_stage
  (input  logic                     clk_i
   , input  logic                   reset_i

   , input  uce_pkg::mem_msg_s      mem_resp_i
   , input  logic                   mem_resp_v_i
   , output logic                   mem_resp_yumi_o

   , output uce_pkg::tag_mem_pkt_s  tag_mem_pkt_o
   , output logic                   tag_mem_pkt_v_o
   , input  logic                   tag_mem_pkt_yumi_i

   , output uce_pkg::data_mem_pkt_s data_mem_pkt_o
   , output logic                   data_mem_pkt_v_o
   , input  logic                   data_mem_pkt_yumi_i

   , output logic                   sweep_done_o
   , output logic                   req_complete_o
   );

  logic sweep_done_r;
  logic [`UCE_INDEX_WIDTH-1:0] sweep_idx_r;
  logic [`UCE_BEAT_CNT_WIDTH-1:0] fill_cnt_r;
  logic tag_sent_r;
  logic data_sent_r;
  logic rd_v;
  logic uc_rd_v;
  logic uc_wr_v;
  logic tag_taken;
  logic data_taken;
  logic rd_ack;
  logic [`UCE_BEAT_CNT_WIDTH-1:0] resp_beat;
  logic [`UCE_INDEX_WIDTH-1:0] resp_index;

  // responses wait until the sweep has finished
  assign rd_v    = sweep_done_r && mem_resp_v_i && (mem_resp_i.msg_type == uce_pkg::e_mem_rd);
  assign uc_rd_v = sweep_done_r && mem_resp_v_i && (mem_resp_i.msg_type == uce_pkg::e_mem_uc_rd);
  assign uc_wr_v = sweep_done_r && mem_resp_v_i && (mem_resp_i.msg_type == uce_pkg::e_mem_uc_wr);

  assign resp_beat  = mem_resp_i.addr[`UCE_BLOCK_OFFSET_WIDTH-1 -: `UCE_BEAT_CNT_WIDTH];
  assign resp_index = mem_resp_i.addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH];

  // tag and data of a beat may be taken in different cycles
  assign tag_taken  = tag_sent_r || tag_mem_pkt_yumi_i;
  assign data_taken = data_sent_r || data_mem_pkt_yumi_i;
  assign rd_ack     = rd_v && tag_taken && data_taken;

  assign tag_mem_pkt_v_o  = !sweep_done_r || (rd_v && !tag_sent_r);
  assign data_mem_pkt_v_o = (rd_v && !data_sent_r) || uc_rd_v;
  assign mem_resp_yumi_o  = rd_ack || (uc_rd_v && data_mem_pkt_yumi_i) || uc_wr_v;
  assign req_complete_o   = (rd_ack && (&fill_cnt_r)) || (uc_rd_v && data_mem_pkt_yumi_i);
  assign sweep_done_o     = sweep_done_r;

  always_comb
  begin
    tag_mem_pkt_o = '0;
    if (!sweep_done_r)
    begin
      tag_mem_pkt_o.opcode = uce_pkg::e_tag_clear;
      tag_mem_pkt_o.index  = sweep_idx_r;
      tag_mem_pkt_o.state  = uce_pkg::e_coh_i;
    end
    else
    begin
      // fill straight into M, nothing else shares the block
      tag_mem_pkt_o.opcode = uce_pkg::e_tag_set;
      tag_mem_pkt_o.index  = resp_index;
      tag_mem_pkt_o.way    = mem_resp_i.way;
      tag_mem_pkt_o.tag    = mem_resp_i.addr[`UCE_PADDR_WIDTH-1 -: `UCE_TAG_WIDTH];
      tag_mem_pkt_o.state  = uce_pkg::e_coh_m;
    end
  end

  always_comb
  begin
    data_mem_pkt_o       = '0;
    data_mem_pkt_o.index = resp_index;
    data_mem_pkt_o.way   = mem_resp_i.way;
    if (uc_rd_v)
    begin
      data_mem_pkt_o.opcode = uce_pkg::e_data_uncached;
      data_mem_pkt_o.data   = {(`UCE_FILL_WIDTH / `UCE_DWORD_WIDTH)
                               {mem_resp_i.data[`UCE_DWORD_WIDTH-1:0]}};
    end
    else
    begin
      data_mem_pkt_o.opcode                = uce_pkg::e_data_write;
      data_mem_pkt_o.fill_index[resp_beat] = 1'b1;
      data_mem_pkt_o.data                  = mem_resp_i.data;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (reset_i)
    begin
      sweep_done_r <= 1'b0;
      sweep_idx_r  <= '0;
      fill_cnt_r   <= '0;
      tag_sent_r   <= 1'b0;
      data_sent_r  <= 1'b0;
    end
    else
    begin
      if (!sweep_done_r && tag_mem_pkt_yumi_i)
      begin
        sweep_idx_r  <= sweep_idx_r + 1'b1;
        sweep_done_r <= &sweep_idx_r;
      end
      if (rd_ack)
      begin
        tag_sent_r  <= 1'b0;
        data_sent_r <= 1'b0;
        fill_cnt_r  <= fill_cnt_r + 1'b1;
      end
      else
      begin
        if (rd_v && tag_mem_pkt_yumi_i)
          tag_sent_r <= 1'b1;
        if (rd_v && data_mem_pkt_yumi_i)
          data_sent_r <= 1'b1;
      end
    end
  end

  // nothing is sent to memory before the sweep ends
  assert property (@(posedge clk_i) disable iff (reset_i)
    !sweep_done_r |-> !mem_resp_v_i)
    else $error("memory response during sweep");

  // a new request needs a fresh command before it can complete
  assert property (@(posedge clk_i) disable iff (reset_i)
    req_complete_o |=> !req_complete_o)
    else $error("back to back completion");

endmodule

`default_nettype wire

//--- source/uce_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "uce_params.svh"

module uce_top
  (input  logic                     clk_i
   , input  logic                   reset_i

   , input  uce_pkg::cache_req_s    cache_req_i
   , input  logic                   cache_req_v_i
   , output logic                   cache_req_yumi_o
   , output logic                   cache_req_busy_o
   , output logic                   cache_req_complete_o
   , output logic                   cache_req_credits_full_o
   , output logic                   cache_req_credits_empty_o

   , output uce_pkg::tag_mem_pkt_s  tag_mem_pkt_o
   , output logic                   tag_mem_pkt_v_o
   , input  logic                   tag_mem_pkt_yumi_i

   , output uce_pkg::data_mem_pkt_s data_mem_pkt_o
   , output logic                   data_mem_pkt_v_o
   , input  logic                   data_mem_pkt_yumi_i

   , output uce_pkg::mem_msg_s      mem_cmd_o
   , output logic                   mem_cmd_v_o
   , input  logic                   mem_cmd_ready_i

   , input  uce_pkg::mem_msg_s      mem_resp_i
   , input  logic                   mem_resp_v_i
   , output logic                   mem_resp_yumi_o
   );

  logic sweep_done;
  logic req_complete;

  uce_cmd_stage cmd_stage
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cache_req_i(cache_req_i)
     ,.cache_req_v_i(cache_req_v_i)
     ,.cache_req_yumi_o(cache_req_yumi_o)
     ,.cache_req_busy_o(cache_req_busy_o)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.sweep_done_i(sweep_done)
     ,.credits_full_i(cache_req_credits_full_o)
     ,.req_complete_i(req_complete)
     );

  uce_fill_stage fill_stage
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     ,.tag_mem_pkt_o(tag_mem_pkt_o)
     ,.tag_mem_pkt_v_o(tag_mem_pkt_v_o)
     ,.tag_mem_pkt_yumi_i(tag_mem_pkt_yumi_i)
     ,.data_mem_pkt_o(data_mem_pkt_o)
     ,.data_mem_pkt_v_o(data_mem_pkt_v_o)
     ,.data_mem_pkt_yumi_i(data_mem_pkt_yumi_i)
     ,.sweep_done_o(sweep_done)
     ,.req_complete_o(req_complete)
     );

  // every valid command is a transfer, every yumi returns a credit
  uce_credit_counter credit_counter
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cmd_sent_i(mem_cmd_v_o)
     ,.resp_taken_i(mem_resp_yumi_o)
     ,.credits_full_o(cache_req_credits_full_o)
     ,.credits_empty_o(cache_req_credits_empty_o)
     );

  assign cache_req_complete_o = req_complete;

endmodule

`default_nettype wire

//--- verification/uce_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "uce_params.svh"

module uce_tb;

  localparam int num_reqs_lp = 18;
  localparam int num_waiting_lp = 12;
  localparam int timeout_cycles_lp = `UCE_SETS + num_reqs_lp * 40 + 200;

  typedef struct packed
  {
    uce_pkg::mem_msg_s msg;
    logic [31:0]       due;
  } pending_s;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;

  uce_pkg::cache_req_s    cache_req_i = '0;
  logic                   cache_req_v_i = 1'b0;
  logic                   cache_req_yumi_o;
  logic                   cache_req_busy_o;
  logic                   cache_req_complete_o;
  logic                   cache_req_credits_full_o;
  logic                   cache_req_credits_empty_o;
  uce_pkg::tag_mem_pkt_s  tag_mem_pkt_o;
  logic                   tag_mem_pkt_v_o;
  logic                   tag_mem_pkt_yumi_i;
  uce_pkg::data_mem_pkt_s data_mem_pkt_o;
  logic                   data_mem_pkt_v_o;
  logic                   data_mem_pkt_yumi_i;
  uce_pkg::mem_msg_s      mem_cmd_o;
  logic                   mem_cmd_v_o;
  logic                   mem_cmd_ready_i = 1'b0;
  uce_pkg::mem_msg_s      mem_resp_i = '0;
  logic                   mem_resp_v_i = 1'b0;
  logic                   mem_resp_yumi_o;

  logic tag_go = 1'b0;
  logic data_go = 1'b0;
  logic [31:0] rand_state = 32'h0;
  logic [31:0] stall_seed = 32'h0;
  logic [31:0] cycle_cnt;

  uce_pkg::cache_req_s req_list [num_reqs_lp];
  uce_pkg::cache_req_s sb_q [$];
  pending_s mem_q [$];
  pending_s pend;

  // state of the request in flight, kept by the testbench
  uce_pkg::cache_req_s cur_req;
  int          req_idx;
  int          completions;
  int          outstanding;
  logic [4:0]  sweep_exp;
  logic [2:0]  beats_sent;
  logic [2:0]  uc_sent;
  logic [2:0]  fills_done;
  logic [`UCE_BEATS-1:0] filled_mask;

  uce_top dut_i
    (.clk_i(clk_i)
     ,.reset_i(reset_i)
     ,.cache_req_i(cache_req_i)
     ,.cache_req_v_i(cache_req_v_i)
     ,.cache_req_yumi_o(cache_req_yumi_o)
     ,.cache_req_busy_o(cache_req_busy_o)
     ,.cache_req_complete_o(cache_req_complete_o)
     ,.cache_req_credits_full_o(cache_req_credits_full_o)
     ,.cache_req_credits_empty_o(cache_req_credits_empty_o)
     ,.tag_mem_pkt_o(tag_mem_pkt_o)
     ,.tag_mem_pkt_v_o(tag_mem_pkt_v_o)
     ,.tag_mem_pkt_yumi_i(tag_mem_pkt_yumi_i)
     ,.data_mem_pkt_o(data_mem_pkt_o)
     ,.data_mem_pkt_v_o(data_mem_pkt_v_o)
     ,.data_mem_pkt_yumi_i(data_mem_pkt_yumi_i)
     ,.mem_cmd_o(mem_cmd_o)
     ,.mem_cmd_v_o(mem_cmd_v_o)
     ,.mem_cmd_ready_i(mem_cmd_ready_i)
     ,.mem_resp_i(mem_resp_i)
     ,.mem_resp_v_i(mem_resp_v_i)
     ,.mem_resp_yumi_o(mem_resp_yumi_o)
     );

  always #2 clk_i = ~clk_i;

  // the cache takes a packet only while it is offered
  assign tag_mem_pkt_yumi_i  = tag_mem_pkt_v_o && tag_go;
  assign data_mem_pkt_yumi_i = data_mem_pkt_v_o && data_go;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // memory contents seen by reads
  function automatic logic [`UCE_DWORD_WIDTH-1:0] beat_data(input logic [31:0] addr);
    return {xorshift(~addr), xorshift(addr)};
  endfunction

  function automatic logic [31:0] miss_beat_addr(input logic [31:0] addr,
                                                 input logic [1:0] beat);
    return {addr[31:5], beat, 3'b000};
  endfunction

  function automatic logic [1:0] onehot_beat(input logic [`UCE_BEATS-1:0] oh);
    logic [1:0] b;
    b = 2'd0;
    for (int i = 0; i < `UCE_BEATS; i++)
      if (oh[i])
        b = 2'(i);
    return b;
  endfunction

  function automatic bit work_finished();
    return (completions == num_waiting_lp) && (req_idx == num_reqs_lp)
      && (outstanding == 0) && (mem_q.size() == 0);
  endfunction

  task automatic stop_with_error(input string line);
    $display("%s", line);
    $display("test failed");
    $fatal(1, "run stopped at first error");
  endtask

  always @(posedge clk_i)
  begin
    if (reset_i)
      cycle_cnt <= '0;
    else
      cycle_cnt <= cycle_cnt + 32'd1;
  end

  // scoreboard and memory model bookkeeping
  always @(posedge clk_i)
  begin
    if (reset_i)
    begin
      cur_req     <= '0;
      req_idx     <= 0;
      completions <= 0;
      outstanding <= 0;
      sweep_exp   <= '0;
      beats_sent  <= '0;
      uc_sent     <= '0;
      fills_done  <= '0;
      filled_mask <= '0;
      mem_q.delete();
      sb_q.delete();
    end
    else
    begin
      if (tag_mem_pkt_yumi_i && tag_mem_pkt_o.opcode == uce_pkg::e_tag_clear)
        sweep_exp <= sweep_exp + 5'd1;
      if (cache_req_yumi_o)
      begin
        req_idx <= req_idx + 1;
        if (cache_req_i.msg_type != uce_pkg::e_uc_store)
        begin
          cur_req     <= cache_req_i;
          beats_sent  <= '0;
          uc_sent     <= '0;
          fills_done  <= '0;
          filled_mask <= '0;
          sb_q.push_back(cache_req_i);
        end
      end
      if (mem_cmd_v_o)
      begin
        pend.msg = mem_cmd_o;
        if (mem_cmd_o.msg_type != uce_pkg::e_mem_uc_wr)
          pend.msg.data = beat_data(mem_cmd_o.addr);
        pend.due = cycle_cnt + 32'd1 + {29'd0, rand_state[10:8]};
        mem_q.push_back(pend);
        if (!cache_req_yumi_o && cur_req.msg_type == uce_pkg::e_miss_load)
          beats_sent <= beats_sent + 3'd1;
        else if (!cache_req_yumi_o)
          uc_sent <= uc_sent + 3'd1;
      end
      if (data_mem_pkt_yumi_i && data_mem_pkt_o.opcode == uce_pkg::e_data_write)
        filled_mask <= filled_mask | data_mem_pkt_o.fill_index;
      if (mem_resp_yumi_o)
      begin
        if (mem_resp_i.msg_type == uce_pkg::e_mem_rd)
          fills_done <= fills_done + 3'd1;
        void'(mem_q.pop_front());
      end
      outstanding <= outstanding + int'(mem_cmd_v_o) - int'(mem_resp_yumi_o);
      if (cache_req_complete_o)
      begin
        completions <= completions + 1;
        void'(sb_q.pop_front());
      end
    end
  end

  always @(negedge clk_i)
  begin
    if (reset_i)
      rand_state = stall_seed;
    else
    begin
      rand_state = xorshift(rand_state);
      mem_cmd_ready_i = |rand_state[1:0];
      tag_go = |rand_state[3:2];
      data_go = |rand_state[5:4];
      cache_req_v_i = (req_idx < num_reqs_lp);
      if (req_idx < num_reqs_lp)
        cache_req_i = req_list[req_idx];
      if (mem_q.size() > 0 && mem_q[0].due <= cycle_cnt)
      begin
        mem_resp_v_i = 1'b1;
        mem_resp_i = mem_q[0].msg;
      end
      else
      begin
        mem_resp_v_i = 1'b0;
        mem_resp_i = '0;
      end
    end
  end

  sweep_order_a: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == uce_pkg::e_tag_clear |->
      sweep_exp < 5'd16 && tag_mem_pkt_o.index == sweep_exp[`UCE_INDEX_WIDTH-1:0]
      && tag_mem_pkt_o.way == '0 && tag_mem_pkt_o.state == uce_pkg::e_coh_i
      && cache_req_busy_o)
    else stop_with_error($sformatf("MISMATCH at %0t: tag clear out of order", $time));

  busy_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_busy_o |-> !cache_req_yumi_o)
    else stop_with_error($sformatf("MISMATCH at %0t: request taken while busy", $time));

  store_cmd_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_yumi_o && cache_req_i.msg_type == uce_pkg::e_uc_store |->
      mem_cmd_v_o && mem_cmd_o.msg_type == uce_pkg::e_mem_uc_wr
      && mem_cmd_o.addr == cache_req_i.addr && mem_cmd_o.size == cache_req_i.size
      && mem_cmd_o.data[`UCE_DWORD_WIDTH-1:0] == cache_req_i.data)
    else stop_with_error($sformatf("MISMATCH at %0t: store command wrong", $time));

  uc_cmd_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o && !cache_req_yumi_o && cur_req.msg_type == uce_pkg::e_uc_load |->
      mem_cmd_o.msg_type == uce_pkg::e_mem_uc_rd && mem_cmd_o.addr == cur_req.addr
      && uc_sent == 3'd0)
    else stop_with_error($sformatf("MISMATCH at %0t: uncached load command wrong", $time));

  // beats wrap around from the critical one
  miss_cmd_a: assert property (@(posedge clk_i) disable iff (reset_i)
    mem_cmd_v_o && !cache_req_yumi_o && cur_req.msg_type == uce_pkg::e_miss_load |->
      mem_cmd_o.msg_type == uce_pkg::e_mem_rd && beats_sent < 3'd4
      && mem_cmd_o.way == cur_req.way
      && mem_cmd_o.addr == miss_beat_addr(cur_req.addr, cur_req.addr[4:3] + beats_sent[1:0]))
    else stop_with_error($sformatf("MISMATCH at %0t: miss beat command wrong", $time));

  uc_data_a: assert property (@(posedge clk_i) disable iff (reset_i)
    data_mem_pkt_v_o && data_mem_pkt_o.opcode == uce_pkg::e_data_uncached |->
      uc_sent == 3'd1 && cur_req.msg_type == uce_pkg::e_uc_load
      && data_mem_pkt_o.data ==
         {(`UCE_FILL_WIDTH / `UCE_DWORD_WIDTH){beat_data(cur_req.addr)}})
    else stop_with_error($sformatf("MISMATCH at %0t: uncached data packet wrong", $time));

  tag_set_a: assert property (@(posedge clk_i) disable iff (reset_i)
    tag_mem_pkt_v_o && tag_mem_pkt_o.opcode == uce_pkg::e_tag_set |->
      tag_mem_pkt_o.state == uce_pkg::e_coh_m && tag_mem_pkt_o.way == cur_req.way
      && tag_mem_pkt_o.tag == cur_req.addr[`UCE_PADDR_WIDTH-1 -: `UCE_TAG_WIDTH]
      && tag_mem_pkt_o.index == cur_req.addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH])
    else stop_with_error($sformatf("MISMATCH at %0t: fill tag packet wrong", $time));

  data_write_a: assert property (@(posedge clk_i) disable iff (reset_i)
    data_mem_pkt_v_o && data_mem_pkt_o.opcode == uce_pkg::e_data_write |->
      $onehot(data_mem_pkt_o.fill_index) && (data_mem_pkt_o.fill_index & filled_mask) == '0
      && data_mem_pkt_o.way == cur_req.way
      && data_mem_pkt_o.index == cur_req.addr[`UCE_BLOCK_OFFSET_WIDTH +: `UCE_INDEX_WIDTH]
      && data_mem_pkt_o.data == beat_data(miss_beat_addr(cur_req.addr,
                                          onehot_beat(data_mem_pkt_o.fill_index))))
    else stop_with_error($sformatf("MISMATCH at %0t: fill data packet wrong", $time));

  complete_a: assert property (@(posedge clk_i) disable iff (reset_i)
    cache_req_complete_o |->
      (cur_req.msg_type == uce_pkg::e_miss_load)
        ? (fills_done == 3'd3 && beats_sent == 3'd4 && mem_resp_yumi_o)
        : (cur_req.msg_type == uce_pkg::e_uc_load && data_mem_pkt_yumi_i
           && data_mem_pkt_o.opcode == uce_pkg::e_data_uncached))
    else stop_with_error($sformatf("MISMATCH at %0t: completion at wrong time", $time));

  uc_done_a: assert property (@(posedge clk_i) disable iff (reset_i)
    data_mem_pkt_yumi_i && data_mem_pkt_o.opcode == uce_pkg::e_data_uncached |->
      cache_req_complete_o)
    else stop_with_error($sformatf("MISMATCH at %0t: uncached load not completed", $time));

  credits_a: assert property (@(posedge clk_i) disable iff (reset_i)
    outstanding <= `UCE_MAX_CREDITS
    && cache_req_credits_full_o == (outstanding == `UCE_MAX_CREDITS)
    && cache_req_credits_empty_o == (outstanding == 0))
    else stop_with_error($sformatf("MISMATCH at %0t: credit flags disagree with count %0d",
                                   $time, outstanding));

  initial
  begin
    logic [31:0] r;
    int j;
    uce_pkg::cache_req_s tmp;

    r = 32'h413f9abd;
    for (int i = 0; i < num_reqs_lp; i++)
    begin
      r = xorshift(r);
      req_list[i] = '0;
      req_list[i].addr = r;
      r = xorshift(r);
      // critical beat
      req_list[i].addr[4:3] = r[1:0];
      req_list[i].way = r[5:4];
      if (i < 6)
        req_list[i].msg_type = uce_pkg::e_uc_store;
      else if (i < 12)
        req_list[i].msg_type = uce_pkg::e_uc_load;
      else
        req_list[i].msg_type = uce_pkg::e_miss_load;
      if (i < 12)
        req_list[i].size = uce_pkg::req_size_e'(r[3:2]);
      else
        req_list[i].size = uce_pkg::e_size_8;
      r = xorshift(r);
      req_list[i].data = {r, xorshift(r)};
    end
    for (int i = num_reqs_lp - 1; i > 0; i--)
    begin
      r = xorshift(r);
      j = int'(r[15:0]) % (i + 1);
      tmp = req_list[i];
      req_list[i] = req_list[j];
      req_list[j] = tmp;
    end
    stall_seed = xorshift(r);

    repeat (8) @(negedge clk_i);
    reset_i = 1'b0;

    while (!work_finished() && cycle_cnt < timeout_cycles_lp)
      @(negedge clk_i);

    if (work_finished() && sb_q.size() == 0 && sweep_exp == 5'd16)
    begin
      $display("test passed");
      $finish;
    end
    else if (!work_finished())
      stop_with_error($sformatf("timeout after %0d cycles, %0d of %0d requests completed",
                                cycle_cnt, completions, num_waiting_lp));
    else
      stop_with_error($sformatf("MISMATCH at %0t: sweep or scoreboard incomplete at end",
                                $time));
  end

endmodule

`default_nettype wire

//--- vlog.f
+incdir+source
source/uce_pkg.sv
source/uce_credit_counter.sv
source/uce_cmd_stage.sv
source/uce_fill_stage.sv
source/uce_top.sv
verification/uce_tb.sv

//--- run.sh
#!/bin/sh
# compile and run with Verilator, exit status follows the testbench
cd "$(dirname "$0")" \
  && verilator --binary --timing --assert -Wno-fatal -f vlog.f \
       --top-module uce_tb -o uce_sim \
  && ./obj_dir/uce_sim \
  || exit 1
